//--- verilog/mem_pkg.sv
// memory read channel types
// one beat carries a single pixel, so no size or burst fields
// requests ask for a run of consecutive bytes

package mem_pkg;

	// byte address into external memory
	typedef logic [31:0] addr_t;

	// read request, one per block line
	typedef struct packed {
		addr_t       addr;
		logic [15:0] len;   // burst length in beats
	} rd_req_t;

	// returned read beat
	typedef struct packed {
		logic [7:0] pixel;
		logic       last;   // final beat of the burst
	} rd_beat_t;

endpackage

//--- verilog/wiener_pkg.sv
// wiener denoiser types and constants
// pixel, per-block statistics and frame configuration,
// plus the slot count and gain precision shared by the datapath

package wiener_pkg;

	// 8-bit greyscale pixel
	typedef logic [7:0] pixel_t;

	// frame configuration captured at start
	typedef struct packed {
		mem_pkg::addr_t base;
		logic [15:0]    width;    // multiple of the block size
		logic [15:0]    height;   // multiple of the block size
		logic [15:0]    noise;    // noise variance
	} frame_cfg_t;

	// statistics of one block
	typedef struct packed {
		logic [7:0]  mean;
		logic [15:0] variance;
	} blk_stats_t;

	localparam int NUM_SLOTS = 2;   // blocks in flight
	localparam int GAIN_FRAC = 8;   // fraction bits of the gain

endpackage

//--- verilog/block_reader.sv
// block reader
// walks the frame block by block, one read burst per block line,
// and forwards returned beats to the statistics unit and the buffer.
// a block's first request needs a slot credit; the filter returns
// credits as it drains buffer slots. owns the busy flag of the frame

module block_reader #(
	parameter int BLOCK_SIZE = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  wiener_pkg::frame_cfg_t cfg,
	output logic                   busy,
	input  logic                   done_in,
	output mem_pkg::rd_req_t       req,
	output logic                   req_valid,
	input  logic                   req_ready,
	input  logic                   beat_valid,
	input  mem_pkg::rd_beat_t      beat,
	output logic                   wr,
	output wiener_pkg::pixel_t     wr_pixel,
	input  logic                   slot_free
);

	localparam int LOG_BS = $clog2(BLOCK_SIZE);
	localparam int CW     = $clog2(wiener_pkg::NUM_SLOTS + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_RECV,
		ST_WAIT
	} state_t;

	state_t                 state;
	wiener_pkg::frame_cfg_t cfg_q;
	logic [15:0]            br;         // block row
	logic [15:0]            bc;         // block column
	logic [LOG_BS-1:0]      y;          // line inside the block
	logic [CW-1:0]          credits;
	logic                   busy_r;
	logic                   start_acc;
	logic                   credit_avail;
	logic                   take;
	logic                   line_end;
	logic                   blk_end;
	logic                   frame_end;
	logic [15:0]            blocks_w;
	logic [15:0]            blocks_h;
	logic [15:0]            line_idx;

	assign blocks_w  = cfg_q.width >> LOG_BS;
	assign blocks_h  = cfg_q.height >> LOG_BS;
	assign start_acc = start && !busy;   // start while busy is dropped
	assign busy      = busy_r && !done_in;

	assign credit_avail = (credits != '0) || slot_free;
	assign line_end     = (state == ST_RECV) && beat_valid && beat.last;
	assign blk_end      = line_end && (y == LOG_BS'(BLOCK_SIZE - 1));
	assign frame_end    = blk_end && (bc == blocks_w - 16'd1) && (br == blocks_h - 16'd1);
	assign take         = ((blk_end && !frame_end) || (state == ST_WAIT)) && credit_avail;

	// frame line of the current request
	assign line_idx  = (br << LOG_BS) | 16'(y);
	assign req.addr  = cfg_q.base
		+ mem_pkg::addr_t'(line_idx) * mem_pkg::addr_t'(cfg_q.width)
		+ mem_pkg::addr_t'(bc << LOG_BS);
	assign req.len   = 16'(BLOCK_SIZE);
	assign req_valid = (state == ST_REQ);

	// beats go straight on as buffer writes
	assign wr       = (state == ST_RECV) && beat_valid;
	assign wr_pixel = beat.pixel;

	always_ff @(posedge clk) begin
		if (start_acc)
			cfg_q <= cfg;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			br     <= '0;
			bc     <= '0;
			y      <= '0;
			busy_r <= 1'b0;
		end else begin
			if (start_acc)
				busy_r <= 1'b1;
			else if (done_in)
				busy_r <= 1'b0;   // held until the last pixel leaves the filter

			case (state)
				ST_IDLE: begin
					if (start_acc) begin
						br    <= '0;
						bc    <= '0;
						y     <= '0;
						state <= ST_REQ;   // first credit taken at start
					end
				end
				ST_REQ: begin
					if (req_ready)
						state <= ST_RECV;
				end
				ST_RECV: begin
					if (line_end) begin
						if (!blk_end) begin
							y     <= y + 1'b1;
							state <= ST_REQ;
						end else if (frame_end) begin
							y     <= '0;
							state <= ST_IDLE;
						end else begin
							y <= '0;
							if (bc == blocks_w - 16'd1) begin
								bc <= '0;
								br <= br + 16'd1;
							end else begin
								bc <= bc + 16'd1;
							end
							state <= credit_avail ? ST_REQ : ST_WAIT;
						end
					end
				end
				ST_WAIT: begin
					if (credit_avail)
						state <= ST_REQ;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// slot credits, one per free buffer slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credits <= CW'(wiener_pkg::NUM_SLOTS);
		else if (start_acc)
			credits <= CW'(wiener_pkg::NUM_SLOTS - 1);
		else
			credits <= credits + CW'(slot_free) - CW'(take);
	end

endmodule

//--- verilog/block_stats.sv
// block statistics
// sums pixels and squared pixels over one block, then turns the totals
// into mean and variance and queues them for the gain unit

module block_stats #(
	parameter int BLOCK_SIZE = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr,
	input  wiener_pkg::pixel_t     wr_pixel,
	output wiener_pkg::blk_stats_t stats,
	output logic                   stats_valid,
	input  logic                   stats_pop
);

	localparam int NPIX  = BLOCK_SIZE * BLOCK_SIZE;
	localparam int LOG_N = $clog2(NPIX);
	localparam int SW    = 8 + LOG_N;
	localparam int QW    = 16 + LOG_N;
	localparam int DEPTH = wiener_pkg::NUM_SLOTS;
	localparam int PW    = $clog2(DEPTH);
	localparam int CNTW  = $clog2(DEPTH + 1);

	logic [LOG_N-1:0]       cnt;
	logic [SW-1:0]          sum;
	logic [SW-1:0]          sum_fin;
	logic [QW-1:0]          sq;
	logic [QW-1:0]          sq_fin;
	logic [15:0]            sq_px;
	logic                   blk_done;
	logic [7:0]             mean_c;
	logic [15:0]            mean_sq;
	wiener_pkg::blk_stats_t res_c;
	wiener_pkg::blk_stats_t q [DEPTH];
	logic [PW-1:0]          wptr;
	logic [PW-1:0]          rptr;
	logic [CNTW-1:0]        fill;

	assign sq_px   = wr_pixel * wr_pixel;
	assign mean_c  = sum_fin[SW-1:LOG_N];
	assign mean_sq = mean_c * mean_c;
	assign res_c   = '{mean: mean_c, variance: sq_fin[QW-1:LOG_N] - mean_sq};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt      <= '0;
			sum      <= '0;
			sq       <= '0;
			blk_done <= 1'b0;
		end else begin
			blk_done <= 1'b0;
			if (wr) begin
				cnt <= cnt + 1'b1;   // wraps at the block end
				if (cnt == LOG_N'(NPIX - 1)) begin
					sum_fin  <= sum + SW'(wr_pixel);
					sq_fin   <= sq + QW'(sq_px);
					sum      <= '0;
					sq       <= '0;
					blk_done <= 1'b1;
				end else begin
					sum <= sum + SW'(wr_pixel);
					sq  <= sq + QW'(sq_px);
				end
			end
		end
	end

	// result queue, slot credits keep it from overflowing
	always_ff @(posedge clk) begin
		if (blk_done)
			q[wptr] <= res_c;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			fill <= '0;
		end else begin
			if (blk_done)
				wptr <= (wptr == PW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (stats_pop)
				rptr <= (rptr == PW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			fill <= fill + CNTW'(blk_done) - CNTW'(stats_pop);
		end
	end

	assign stats       = q[rptr];
	assign stats_valid = (fill != '0);

endmodule

//--- verilog/block_buffer.sv
// block pixel buffer
// holds NUM_SLOTS blocks; writes fill the slots in order as beats
// arrive, reads drain them in the same order one pixel per rd_en,
// with the pixel out on the following cycle

module block_buffer #(
	parameter int BLOCK_SIZE = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  wiener_pkg::pixel_t wr_pixel,
	input  logic               rd_en,
	output wiener_pkg::pixel_t rd_pixel
);

	localparam int NPIX  = BLOCK_SIZE * BLOCK_SIZE;
	localparam int DEPTH = wiener_pkg::NUM_SLOTS * NPIX;
	localparam int AW    = $clog2(DEPTH);

	wiener_pkg::pixel_t mem [DEPTH];
	logic [AW-1:0]      wr_ptr;
	logic [AW-1:0]      rd_ptr;
	logic               wr_wrap;
	logic               rd_wrap;

	// end of the last slot
	assign wr_wrap = (wr_ptr == AW'(DEPTH - 1));
	assign rd_wrap = (rd_ptr == AW'(DEPTH - 1));

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= wr_pixel;
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			rd_pixel <= mem[rd_ptr];   // valid one cycle after rd_en
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_wrap ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_wrap ? '0 : rd_ptr + 1'b1;
		end
	end

endmodule

//--- verilog/wiener_gain.sv
// wiener gain and filter
// pops block statistics, divides (v - noise) << GAIN_FRAC by v with a
// restoring serial divider, then filters the block's pixels while
// output credits last. returns the slot once the block is read and
// pulses done after the frame's last pixel

module wiener_gain #(
	parameter int BLOCK_SIZE = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [15:0]            cfg_noise,
	input  logic [31:0]            frame_pixels,
	input  wiener_pkg::blk_stats_t stats,
	input  logic                   stats_valid,
	output logic                   stats_pop,
	output logic                   rd_en,
	input  wiener_pkg::pixel_t     rd_pixel,
	output logic                   slot_free,
	output wiener_pkg::pixel_t     out_pixel,
	output logic                   out_valid,
	input  logic                   out_credit,
	output logic                   done
);

	localparam int NPIX    = BLOCK_SIZE * BLOCK_SIZE;
	localparam int LOG_N   = $clog2(NPIX);
	localparam int DIV_CYC = 2 * BLOCK_SIZE;
	localparam int DCW     = $clog2(DIV_CYC);
	localparam int DW      = 16 + DIV_CYC;
	localparam int GF      = wiener_pkg::GAIN_FRAC;
	localparam int GW      = GF + 1;   // gain reaches 1.0 when noise is 0

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DIV,
		ST_FILT
	} state_t;

	state_t              state;
	logic [7:0]          mean_q;
	logic [GW-1:0]       gain;
	logic [DW-1:0]       rem;
	logic [DW-1:0]       dsh;        // divisor aligned to the current bit
	logic [DCW-1:0]      div_cnt;
	logic [LOG_N-1:0]    rd_idx;
	logic [15:0]         credits;
	logic [31:0]         out_cnt;
	logic [15:0]         excess;
	logic [15+GF:0]      num_c;
	logic [15:0]         den_c;
	logic                q_bit;
	logic signed [9:0]   diff;
	logic signed [19:0]  prod;
	logic signed [19:0]  res;

	// v <= noise gives a zero numerator, divisor forced to 1
	always_comb begin
		excess = stats.variance - cfg_noise;
		if (stats.variance > cfg_noise) begin
			num_c = {excess, {GF{1'b0}}};
			den_c = stats.variance;
		end else begin
			num_c = '0;
			den_c = 16'd1;
		end
	end

	assign q_bit     = (rem >= dsh);
	assign stats_pop = (state == ST_IDLE) && stats_valid;
	assign rd_en     = (state == ST_FILT) && (credits > 16'(out_valid));   // one read in flight

	// filter on the pixel returned by the buffer
	assign diff = $signed({2'b00, rd_pixel}) - $signed({2'b00, mean_q});
	assign prod = diff * $signed({1'b0, gain});
	assign res  = $signed({12'd0, mean_q}) + (prod >>> GF);
	assign out_pixel = (res < 0) ? 8'd0 : (res > 20'sd255) ? 8'd255 : res[7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			mean_q    <= '0;
			gain      <= '0;
			rem       <= '0;
			dsh       <= '0;
			div_cnt   <= '0;
			rd_idx    <= '0;
			slot_free <= 1'b0;
		end else begin
			slot_free <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (stats_pop) begin
						mean_q  <= stats.mean;
						gain    <= '0;
						rem     <= DW'(num_c);
						dsh     <= DW'(den_c) << (DIV_CYC - 1);
						div_cnt <= DCW'(DIV_CYC - 1);
						state   <= ST_DIV;
					end
				end
				ST_DIV: begin
					if (q_bit)
						rem <= rem - dsh;
					gain <= {gain[GW-2:0], q_bit};
					dsh  <= dsh >> 1;
					div_cnt <= div_cnt - 1'b1;
					if (div_cnt == '0)
						state <= ST_FILT;
				end
				ST_FILT: begin
					if (rd_en) begin
						rd_idx <= rd_idx + 1'b1;
						if (rd_idx == LOG_N'(NPIX - 1)) begin
							slot_free <= 1'b1;   // block fully read
							state     <= ST_IDLE;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// output credits and frame progress
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			credits   <= '0;
			out_cnt   <= '0;
			done      <= 1'b0;
		end else begin
			out_valid <= rd_en;
			credits   <= credits + 16'(out_credit) - 16'(out_valid);
			done      <= out_valid && (out_cnt == frame_pixels - 32'd1);
			if (out_valid)
				out_cnt <= (out_cnt == frame_pixels - 32'd1) ? '0 : out_cnt + 32'd1;
		end
	end

endmodule

//--- verilog/wiener_top.sv
// block wiener denoiser top level
// the reader feeds each beat to the statistics unit and the block
// buffer side by side; the gain unit combines both into the output
// stream under downstream credits

module wiener_top #(
	parameter int BLOCK_SIZE = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  wiener_pkg::frame_cfg_t cfg,
	output logic                   busy,
	output logic                   done,
	output mem_pkg::rd_req_t       req,
	output logic                   req_valid,
	input  logic                   req_ready,
	input  logic                   beat_valid,
	input  mem_pkg::rd_beat_t      beat,
	output wiener_pkg::pixel_t     out_pixel,
	output logic                   out_valid,
	input  logic                   out_credit
);

	wiener_pkg::frame_cfg_t cfg_q;
	logic                   wr;
	wiener_pkg::pixel_t     wr_pixel;
	wiener_pkg::blk_stats_t stats;
	logic                   stats_valid;
	logic                   stats_pop;
	logic                   rd_en;
	wiener_pkg::pixel_t     rd_pixel;
	logic                   slot_free;
	logic [31:0]            frame_pixels;

	// frame settings for the filter side
	always_ff @(posedge clk) begin
		if (start && !busy)
			cfg_q <= cfg;
	end

	assign frame_pixels = 32'(cfg_q.width) * 32'(cfg_q.height);

	block_reader #(.BLOCK_SIZE(BLOCK_SIZE)) u_reader (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.busy       (busy),
		.done_in    (done),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.beat_valid (beat_valid),
		.beat       (beat),
		.wr         (wr),
		.wr_pixel   (wr_pixel),
		.slot_free  (slot_free)
	);

	block_stats #(.BLOCK_SIZE(BLOCK_SIZE)) u_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.wr_pixel    (wr_pixel),
		.stats       (stats),
		.stats_valid (stats_valid),
		.stats_pop   (stats_pop)
	);

	block_buffer #(.BLOCK_SIZE(BLOCK_SIZE)) u_buffer (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (wr),
		.wr_pixel (wr_pixel),
		.rd_en    (rd_en),
		.rd_pixel (rd_pixel)
	);

	wiener_gain #(.BLOCK_SIZE(BLOCK_SIZE)) u_gain (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg_noise    (cfg_q.noise),
		.frame_pixels (frame_pixels),
		.stats        (stats),
		.stats_valid  (stats_valid),
		.stats_pop    (stats_pop),
		.rd_en        (rd_en),
		.rd_pixel     (rd_pixel),
		.slot_free    (slot_free),
		.out_pixel    (out_pixel),
		.out_valid    (out_valid),
		.out_credit   (out_credit),
		.done         (done)
	);

endmodule

//--- verif/tb_clk_gen.sv
// clock and reset generator
// 4 ns clock, reset held low for the first cycles

module tb_clk_gen #(
	parameter int RST_CYCLES = 4
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;   // released away from the active edge
	end

endmodule

//--- verif/wiener_sva.sv
// protocol checks on the denoiser top level
// read request handshake, output credits, done pulse and
// read beats only inside a frame

module wiener_sva (
	input logic             clk,
	input logic             rst_n,
	input mem_pkg::rd_req_t req,
	input logic             req_valid,
	input logic             req_ready,
	input logic             beat_valid,
	input logic             busy,
	input logic             done,
	input logic             out_valid,
	input logic             out_credit
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] avail;   // credits granted and not yet used

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			avail <= '0;
		else
			avail <= avail + 16'(out_credit) - 16'(out_valid);
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(req))
		else $error("read request dropped or changed while stalled");

	a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> avail != 16'd0)
		else $error("out_valid with no credit left");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held for more than one cycle");

	a_beat_busy: assert property (@(posedge clk) disable iff (!rst_n)
		beat_valid |-> busy)
		else $error("read beat while no frame is running");

endmodule

bind wiener_top wiener_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.req        (req),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.beat_valid (beat_valid),
	.busy       (busy),
	.done       (done),
	.out_valid  (out_valid),
	.out_credit (out_credit)
);

//--- verif/wiener_tb.sv
// testbench for the block wiener denoiser
// memory model with random ready and beat gaps, output credit driver,
// reference model of the block filter and an output compare process

module wiener_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          BS              = 8;
	localparam int          LOG_N           = $clog2(BS * BS);
	localparam int          MEM_SIZE        = 8192;
	localparam logic [31:0] SEED            = 32'h951e_b9f7;
	localparam int          TOTAL_PIXELS    = 256 + 512 + 512 + 512 + 256 + 512;
	localparam int          WATCHDOG_CYCLES = TOTAL_PIXELS * 40 + 200;

	logic                   clk;
	logic                   rst_n;
	logic                   start;
	wiener_pkg::frame_cfg_t cfg;
	logic                   busy;
	logic                   done;
	mem_pkg::rd_req_t       req;
	logic                   req_valid;
	logic                   req_ready;
	logic                   beat_valid;
	mem_pkg::rd_beat_t      beat;
	wiener_pkg::pixel_t     out_pixel;
	logic                   out_valid;
	logic                   out_credit;

	logic [7:0]  mem [MEM_SIZE];
	logic [7:0]  exp_q [$];      // expected output stream
	logic [31:0] mem_lfsr;
	logic [31:0] cr_lfsr;
	logic [31:0] fill_lfsr;
	logic        trickle;        // one credit at a time
	int          burst_addr;
	int          burst_left;
	int          cur_base;
	int          cur_w;
	int          cur_h;
	int          exp_br;
	int          exp_bc;
	int          exp_y;
	int          n_req;
	int          addr_err;
	int          err;
	int          n_fail;
	int          n_out;
	int          credits_seen;
	int          given_cr;
	int          used_cr;

	tb_clk_gen #(.RST_CYCLES(4)) u_clk (.clk(clk), .rst_n(rst_n));

	wiener_top #(.BLOCK_SIZE(BS)) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.cfg        (cfg),
		.busy       (busy),
		.done       (done),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.beat_valid (beat_valid),
		.beat       (beat),
		.out_pixel  (out_pixel),
		.out_valid  (out_valid),
		.out_credit (out_credit)
	);

	// fibonacci lfsr, taps 32 22 2 1, new bits enter at bit 0
	function automatic logic [31:0] lfsr_adv(input logic [31:0] s, input int n);
		logic fb;
		int   i;
		for (i = 0; i < n; i++) begin
			fb = s[31] ^ s[21] ^ s[1] ^ s[0];
			s  = {s[30:0], fb};
		end
		return s;
	endfunction

	// expected filter output for one pixel from its block sums
	function automatic logic [7:0] ref_pixel(input int x, input int sum, input int sumsq,
			input int noise);
		int m;
		int v;
		int g;
		int r;
		m = sum >> LOG_N;
		v = (sumsq >> LOG_N) - m * m;
		if (v > noise)
			g = ((v - noise) << wiener_pkg::GAIN_FRAC) / v;
		else
			g = 0;
		r = m + ((g * (x - m)) >>> wiener_pkg::GAIN_FRAC);
		if (r < 0)
			r = 0;
		else if (r > 255)
			r = 255;
		return 8'(r);
	endfunction

	function automatic int pix_at(input int base, input int w, input int row, input int col);
		return mem[(base + row * w + col) % MEM_SIZE];
	endfunction

	task automatic fill_frame(input int base, input int w, input int h, input bit flat);
		int         r;
		int         c;
		int         blk;
		logic [7:0] mask;
		for (r = 0; r < h; r++) begin
			for (c = 0; c < w; c++) begin
				blk  = (r / BS) * (w / BS) + c / BS;
				mask = blk[0] ? 8'h3f : 8'hff;   // smooth and busy blocks alternate
				if (flat) begin
					mem[base + r * w + c] = 8'h5a;
				end else begin
					fill_lfsr = lfsr_adv(fill_lfsr, 8);
					mem[base + r * w + c] = (fill_lfsr[7:0] & mask) + 8'(blk * 9);
				end
			end
		end
	endtask

	// blocks in raster order, pixels row-major inside a block
	task automatic build_expected(input int base, input int w, input int h, input int noise);
		int br;
		int bc;
		int y;
		int x;
		int sum;
		int sumsq;
		int p;
		for (br = 0; br < h / BS; br++) begin
			for (bc = 0; bc < w / BS; bc++) begin
				sum   = 0;
				sumsq = 0;
				for (y = 0; y < BS; y++) begin
					for (x = 0; x < BS; x++) begin
						p     = pix_at(base, w, br * BS + y, bc * BS + x);
						sum   += p;
						sumsq += p * p;
					end
				end
				for (y = 0; y < BS; y++) begin
					for (x = 0; x < BS; x++) begin
						p = pix_at(base, w, br * BS + y, bc * BS + x);
						exp_q.push_back(ref_pixel(p, sum, sumsq, noise));
					end
				end
			end
		end
	endtask

	task automatic check_request();
		logic [31:0] exp_addr;
		exp_addr = 32'(cur_base + (exp_br * BS + exp_y) * cur_w + exp_bc * BS);
		n_req++;
		if (exp_br >= cur_h / BS) begin
			$display("read request at %h after the last block row of the frame", req.addr);
			addr_err++;
			err++;
		end else if (req.addr !== exp_addr) begin
			$display("FAILED req.addr: got %h expected %h", req.addr, exp_addr);
			addr_err++;
			err++;
		end
		if (req.len !== 16'(BS)) begin
			$display("FAILED req.len: got %h expected %h", req.len, 16'(BS));
			addr_err++;
			err++;
		end
		exp_y++;
		if (exp_y == BS) begin
			exp_y = 0;
			exp_bc++;
			if (exp_bc == cur_w / BS) begin
				exp_bc = 0;
				exp_br++;
			end
		end
	endtask

	task automatic run_frame(input int base, input int w, input int h, input int noise,
			input bit stray, output int pixels, output int errs);
		int   err0;
		int   out0;
		int   cycles;
		logic seen_done;
		err0 = err;
		out0 = n_out;
		build_expected(base, w, h, noise);
		cur_base = base;
		cur_w    = w;
		cur_h    = h;
		exp_br   = 0;
		exp_bc   = 0;
		exp_y    = 0;
		@(negedge clk);
		cfg       = '{base: 32'(base), width: 16'(w), height: 16'(h), noise: 16'(noise)};
		start     = 1'b1;
		cycles    = 0;
		seen_done = 1'b0;
		while (!seen_done) begin
			@(negedge clk);
			cycles++;
			start = 1'b0;
			if (stray && cycles == 30) begin
				if (!busy) begin
					$display("frame was not busy when the second start was tried");
					err++;
				end
				cfg   = '{base: 32'h0000_0040, width: 16'd8, height: 16'd8, noise: 16'd0};
				start = 1'b1;   // should be dropped
			end
			seen_done = done;
		end
		if (busy) begin
			$display("busy still high in the cycle of done");
			err++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected pixels never came out", exp_q.size());
			err++;
			exp_q.delete();
		end
		pixels = n_out - out0;
		errs   = err - err0;
	endtask

	task automatic report_test(input int num, input string name, input int pixels,
			input int errs);
		$display("test %0d %s: %0d pixels, %0d errors", num, name, pixels, errs);
		if (errs != 0)
			n_fail++;
	endtask

	// read memory model, bursts answered in request order
	always @(negedge clk) begin
		beat_valid = 1'b0;
		if (rst_n) begin
			if (burst_left > 0) begin
				mem_lfsr = lfsr_adv(mem_lfsr, 2);
				if (mem_lfsr[1:0] != 2'b00) begin   // about one gap in four
					beat_valid = 1'b1;
					beat.pixel = mem[burst_addr % MEM_SIZE];
					beat.last  = (burst_left == 1);
					burst_addr++;
					burst_left--;
				end
			end
			mem_lfsr  = lfsr_adv(mem_lfsr, 2);
			req_ready = (mem_lfsr[1:0] != 2'b00);
			if (req_valid && req_ready) begin   // taken at the next rising edge
				check_request();
				burst_addr = int'(req.addr);
				burst_left = int'(req.len);
			end
		end
	end

	// downstream credits, a few ahead or one at a time with random gaps
	always @(negedge clk) begin
		if (out_valid)
			used_cr++;
		out_credit = 1'b0;
		if (rst_n) begin
			if (trickle) begin
				if (given_cr == used_cr) begin
					cr_lfsr    = lfsr_adv(cr_lfsr, 2);
					out_credit = (cr_lfsr[1:0] == 2'b00);
				end
			end else begin
				out_credit = (given_cr - used_cr < 4);
			end
			if (out_credit)
				given_cr++;
		end
	end

	always @(posedge clk) begin
		if (out_credit)
			credits_seen++;
	end

	// output compare
	always @(negedge clk) begin
		logic [7:0] exp_px;
		if (out_valid) begin
			n_out++;
			if (n_out > credits_seen) begin
				$display("out_valid without a granted credit (%0d outputs, %0d credits)",
					n_out, credits_seen);
				err++;
			end
			if (exp_q.size() == 0) begin
				$display("output pixel %h came with nothing expected", out_pixel);
				err++;
			end else begin
				exp_px = exp_q.pop_front();
				if (out_pixel !== exp_px) begin
					$display("FAILED out_pixel at output %0d: got %h expected %h",
						n_out - 1, out_pixel, exp_px);
					err++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int px;
		int fe;
		int px2;
		int fe2;
		int i;
		start      = 1'b0;
		cfg        = '0;
		req_ready  = 1'b0;
		beat_valid = 1'b0;
		beat       = '0;
		out_credit = 1'b0;
		trickle    = 1'b0;
		mem_lfsr   = SEED;
		cr_lfsr    = SEED;
		fill_lfsr  = SEED;
		for (i = 0; i < MEM_SIZE; i++)
			mem[i] = 8'(i ^ (i >> 8) ^ 8'h3c);   // background outside the frames
		@(posedge rst_n);
		repeat (2) @(negedge clk);

		fill_frame(32'h0100, 16, 16, 1'b1);
		run_frame(32'h0100, 16, 16, 100, 1'b0, px, fe);
		report_test(1, "flat 16x16 frame", px, fe);

		fill_frame(32'h0400, 32, 16, 1'b0);
		run_frame(32'h0400, 32, 16, 300, 1'b0, px, fe);
		report_test(2, "random 32x16 frame", px, fe);

		fill_frame(32'h0800, 32, 16, 1'b0);
		run_frame(32'h0800, 32, 16, 65535, 1'b0, px, fe);
		report_test(3, "noise above every block variance", px, fe);

		trickle = 1'b1;
		run_frame(32'h0400, 32, 16, 300, 1'b0, px, fe);
		trickle = 1'b0;
		report_test(4, "single credits with gaps", px, fe);

		$display("test 5 address rule: %0d requests checked, %0d mismatches", n_req, addr_err);
		if (addr_err != 0)
			n_fail++;

		fill_frame(32'h0c00, 16, 16, 1'b0);
		fill_frame(32'h1000, 32, 16, 1'b0);
		run_frame(32'h0c00, 16, 16, 200, 1'b1, px, fe);
		run_frame(32'h1000, 32, 16, 500, 1'b0, px2, fe2);
		report_test(6, "start while busy, then new base", px + px2, fe + fe2);

		$display("6 tests, %0d failed, %0d errors in total", n_fail, err);
		if (err == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vlog.f
verilog/mem_pkg.sv
verilog/wiener_pkg.sv
verilog/block_reader.sv
verilog/block_stats.sv
verilog/block_buffer.sv
verilog/wiener_gain.sv
verilog/wiener_top.sv
verif/tb_clk_gen.sv
verif/wiener_sva.sv
verif/wiener_tb.sv

//--- Bender.yml
package:
  name: wiener_denoiser

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/wiener_pkg.sv
      - verilog/block_reader.sv
      - verilog/block_stats.sv
      - verilog/block_buffer.sv
      - verilog/wiener_gain.sv
      - verilog/wiener_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/wiener_sva.sv
      - verif/wiener_tb.sv
